// File: clip_params.svh
`ifndef CLIP_PARAMS_SVH
`define CLIP_PARAMS_SVH

// coordinates above these limits are outside
`define CLIP_SCREEN_W 640
`define CLIP_SCREEN_H 480

// signed coordinate width
`define CLIP_COORD_W 16

`define CLIP_COLOR_W 8

// object store
`define CLIP_OBJ_DEPTH 64
`define CLIP_OBJ_AW 6 // log2 of depth

`endif

// File: geom_pkg.sv
`default_nettype none

`include "clip_params.svh"

package geom_pkg;

    typedef enum logic [1:0] {
        kind_point = 2'd0,
        kind_line  = 2'd1,
        kind_tri   = 2'd2,
        kind_quad  = 2'd3
    } obj_kind_e;

    typedef struct packed {
        logic signed [`CLIP_COORD_W-1:0] y;
        logic signed [`CLIP_COORD_W-1:0] x;
    } vertex_t;

    // v0 sits in the low word
    typedef struct packed {
        obj_kind_e                kind;
        logic [`CLIP_COLOR_W-1:0] color;
        vertex_t                  v3;
        vertex_t                  v2;
        vertex_t                  v1;
        vertex_t                  v0;
    } object_t;

    typedef struct packed {
        logic [`CLIP_COLOR_W-1:0] color;
        vertex_t                  p1; // end point
        vertex_t                  p0; // start point
    } line_t;

    typedef struct packed {
        logic below;
        logic above;
        logic right;
        logic left;
    } outcode_t;

    typedef enum logic [1:0] {
        cls_accept  = 2'd0,
        cls_reject  = 2'd1,
        cls_partial = 2'd2
    } line_class_e;

    typedef struct packed {
        line_t       line;
        outcode_t    oc0;
        outcode_t    oc1;
        line_class_e cls;
    } clipped_line_t;

endpackage

`default_nettype wire

// File: seq_pkg.sv
`default_nettype none

package seq_pkg;

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_fetch = 2'd1,
        st_drain = 2'd2,
        st_flush = 2'd3
    } seq_state_e;

    // one-hot slot phases
    typedef enum logic [3:0] {
        ph_1 = 4'b0001,
        ph_2 = 4'b0010,
        ph_3 = 4'b0100,
        ph_4 = 4'b1000
    } slot_phase_e;

endpackage

`default_nettype wire

// File: obj_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "clip_params.svh"

module obj_store (
    input  wire logic                   clk,
    input  wire logic                   obj_wr,
    input  wire logic [`CLIP_OBJ_AW-1:0] obj_waddr,
    input  wire geom_pkg::object_t      obj_wdata,
    input  wire logic                   rd_en,
    input  wire logic [`CLIP_OBJ_AW-1:0] rd_addr,
    output geom_pkg::object_t           rd_data
);
    import geom_pkg::*;

    object_t                 mem [`CLIP_OBJ_DEPTH];
    logic [`CLIP_OBJ_AW-1:0] addr_q;
    logic                    rd_en_q;

    // host writes only while idle
    always_ff @(posedge clk) begin
        if (obj_wr) begin
            mem[obj_waddr] <= obj_wdata;
        end
    end

    // address stage
    always_ff @(posedge clk) begin
        rd_en_q <= rd_en;
        if (rd_en) begin
            addr_q <= rd_addr;
        end
    end

    // data valid two edges after rd_en
    always_ff @(posedge clk) begin
        if (rd_en_q) begin
            rd_data <= mem[addr_q];
        end
    end

endmodule

`default_nettype wire

// File: clip_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "clip_params.svh"

module clip_ctrl (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    start_refresh,
    input  wire logic [`CLIP_OBJ_AW:0]   num_objs,
    output seq_pkg::slot_phase_e         phase,
    output logic                         obj_vld,
    output logic                         prev_obj_vld,
    output logic                         rd_en,
    output logic [`CLIP_OBJ_AW-1:0]      rd_addr,
    output logic                         busy,
    output logic                         refresh_done
);
    import seq_pkg::*;

    seq_state_e            state;
    slot_phase_e           phase_nxt;
    logic [`CLIP_OBJ_AW:0] obj_idx;
    logic [`CLIP_OBJ_AW:0] num_q;
    logic [1:0]            flush_cnt;
    logic                  slot_end;

    assign slot_end = (phase == ph_4);

    always_comb begin
        case (phase)
            ph_1:    phase_nxt = ph_2;
            ph_2:    phase_nxt = ph_3;
            ph_3:    phase_nxt = ph_4;
            default: phase_nxt = ph_1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_idle;
            phase        <= ph_1;
            obj_idx      <= '0;
            num_q        <= '0;
            flush_cnt    <= '0;
            prev_obj_vld <= 1'b0;
            refresh_done <= 1'b0;
        end else begin
            refresh_done <= 1'b0;
            case (state)
                st_idle: begin
                    phase <= ph_1;
                    if (start_refresh) begin
                        num_q        <= num_objs; // sampled once per refresh
                        obj_idx      <= '0;
                        prev_obj_vld <= 1'b0;
                        if (num_objs == '0) begin
                            state <= st_drain;
                        end else begin
                            state <= st_fetch;
                        end
                    end
                end
                st_fetch: begin
                    phase <= phase_nxt;
                    if (slot_end) begin
                        prev_obj_vld <= obj_vld;
                        obj_idx      <= obj_idx + 1'b1;
                        if (obj_idx + 1'b1 >= num_q) begin
                            state <= st_drain;
                        end
                    end
                end
                st_drain: begin
                    // one slot for the splitter to emit the last object
                    phase <= phase_nxt;
                    if (slot_end) begin
                        prev_obj_vld <= 1'b0;
                        flush_cnt    <= '0;
                        state        <= st_flush;
                    end
                end
                default: begin
                    // let the classifier pipe empty
                    flush_cnt <= flush_cnt + 1'b1;
                    if (flush_cnt == 2'd2) begin
                        refresh_done <= 1'b1;
                        state        <= st_idle;
                    end
                end
            endcase
        end
    end

    assign obj_vld = (state == st_fetch) && (obj_idx < num_q);
    assign rd_en   = obj_vld && (phase == ph_2);
    assign rd_addr = obj_idx[`CLIP_OBJ_AW-1:0];
    assign busy    = (state != st_idle);

endmodule

`default_nettype wire

// File: line_splitter.sv
`timescale 1ns/10ps
`default_nettype none

module line_splitter (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire seq_pkg::slot_phase_e phase,
    input  wire logic                 obj_vld,
    input  wire logic                 prev_obj_vld,
    input  wire logic                 start_refresh,
    input  wire geom_pkg::object_t    obj,
    output logic                      line_wr,
    output geom_pkg::line_t           line,
    output logic [7:0]                line_cnt
);
    import geom_pkg::*;
    import seq_pkg::*;

    object_t obj_q;
    vertex_t edge_p0;
    vertex_t edge_p1;
    logic    edge_en;
    logic    emit;
    logic    is_poly;

    // store data is valid in ph_4
    always_ff @(posedge clk) begin
        if (phase == ph_4 && obj_vld) begin
            obj_q <= obj;
        end
    end

    assign is_poly = (obj_q.kind == kind_tri) || (obj_q.kind == kind_quad);

    // edge that belongs to this phase and kind
    always_comb begin
        edge_en = 1'b0;
        edge_p0 = obj_q.v0;
        edge_p1 = obj_q.v1;
        case (phase)
            ph_1: begin
                edge_en = 1'b1;
                if (obj_q.kind == kind_point) begin
                    edge_p1 = obj_q.v0; // degenerate edge
                end
            end
            ph_2: begin
                edge_en = is_poly;
                edge_p0 = obj_q.v1;
                edge_p1 = obj_q.v2;
            end
            ph_3: begin
                edge_en = is_poly;
                edge_p0 = obj_q.v2;
                if (obj_q.kind == kind_quad) begin
                    edge_p1 = obj_q.v3;
                end else begin
                    edge_p1 = obj_q.v0; // closes the triangle
                end
            end
            ph_4: begin
                edge_en = (obj_q.kind == kind_quad);
                edge_p0 = obj_q.v3;
                edge_p1 = obj_q.v0;
            end
            default: begin
                edge_en = 1'b0;
            end
        endcase
    end

    assign emit = prev_obj_vld && edge_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_wr <= 1'b0;
        end else begin
            line_wr <= emit;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            line.p0    <= edge_p0;
            line.p1    <= edge_p1;
            line.color <= obj_q.color;
        end
    end

    // edges emitted in this refresh
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_cnt <= '0;
        end else if (start_refresh) begin
            line_cnt <= '0;
        end else if (emit) begin
            line_cnt <= line_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: line_classifier.sv
`timescale 1ns/10ps
`default_nettype none

`include "clip_params.svh"

module line_classifier (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              start_refresh,
    input  wire logic              line_wr,
    input  wire geom_pkg::line_t   line,
    output logic                   out_vld,
    output geom_pkg::clipped_line_t out_line,
    output logic [7:0]             reject_cnt
);
    import geom_pkg::*;

    logic        s1_vld;
    line_t       s1_line;
    outcode_t    s1_oc0;
    outcode_t    s1_oc1;
    line_class_e s1_cls;

    function automatic outcode_t outcode_of(input vertex_t v);
        outcode_t oc;
        oc.below = (v.y > `CLIP_SCREEN_H);
        oc.above = (v.y < 0);
        oc.right = (v.x > `CLIP_SCREEN_W);
        oc.left  = (v.x < 0);
        return oc;
    endfunction

    // stage 1 outcodes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld <= 1'b0;
        end else begin
            s1_vld <= line_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (line_wr) begin
            s1_line <= line;
            s1_oc0  <= outcode_of(line.p0);
            s1_oc1  <= outcode_of(line.p1);
        end
    end

    // trivial accept and reject tests
    always_comb begin
        if ((s1_oc0 | s1_oc1) == 4'b0000) begin
            s1_cls = cls_accept;
        end else if ((s1_oc0 & s1_oc1) != 4'b0000) begin
            s1_cls = cls_reject; // both ends beyond the same side
        end else begin
            s1_cls = cls_partial;
        end
    end

    // stage 2 output and reject count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld    <= 1'b0;
            reject_cnt <= '0;
        end else begin
            out_vld <= s1_vld && (s1_cls != cls_reject);
            if (start_refresh) begin
                reject_cnt <= '0;
            end else if (s1_vld && s1_cls == cls_reject) begin
                reject_cnt <= reject_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_vld && s1_cls != cls_reject) begin
            out_line.line <= s1_line;
            out_line.oc0  <= s1_oc0;
            out_line.oc1  <= s1_oc1;
            out_line.cls  <= s1_cls;
        end
    end

endmodule

`default_nettype wire

// File: vector_clip_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "clip_params.svh"

module vector_clip_top (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    obj_wr,
    input  wire logic [`CLIP_OBJ_AW-1:0] obj_waddr,
    input  wire geom_pkg::object_t       obj_wdata,
    input  wire logic                    start_refresh,
    input  wire logic [`CLIP_OBJ_AW:0]   num_objs,
    output logic                         out_vld,
    output geom_pkg::clipped_line_t      out_line,
    output logic [7:0]                   line_cnt,
    output logic [7:0]                   reject_cnt,
    output logic                         busy,
    output logic                         refresh_done
);
    import geom_pkg::*;
    import seq_pkg::*;

    slot_phase_e             phase;
    logic                    obj_vld;
    logic                    prev_obj_vld;
    logic                    rd_en;
    logic [`CLIP_OBJ_AW-1:0] rd_addr;
    object_t                 rd_data;
    logic                    line_wr;
    line_t                   line;

    obj_store u_store (
        .clk       (clk),
        .obj_wr    (obj_wr),
        .obj_waddr (obj_waddr),
        .obj_wdata (obj_wdata),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    clip_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_refresh (start_refresh),
        .num_objs      (num_objs),
        .phase         (phase),
        .obj_vld       (obj_vld),
        .prev_obj_vld  (prev_obj_vld),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .busy          (busy),
        .refresh_done  (refresh_done)
    );

    line_splitter u_split (
        .clk           (clk),
        .rst_n         (rst_n),
        .phase         (phase),
        .obj_vld       (obj_vld),
        .prev_obj_vld  (prev_obj_vld),
        .start_refresh (start_refresh),
        .obj           (rd_data),
        .line_wr       (line_wr),
        .line          (line),
        .line_cnt      (line_cnt)
    );

    line_classifier u_class (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_refresh (start_refresh),
        .line_wr       (line_wr),
        .line          (line),
        .out_vld       (out_vld),
        .out_line      (out_line),
        .reject_cnt    (reject_cnt)
    );

endmodule

`default_nettype wire

// File: tb_vector_clip.sv
`timescale 1ns/10ps
`default_nettype none

`include "clip_params.svh"

module tb_vector_clip;
    import geom_pkg::*;

    localparam int MAX_CYCLES = 4 * (64 + 4) * 8; // eight full refreshes

    logic                    clk;
    logic                    rst_n;
    logic                    obj_wr;
    logic [`CLIP_OBJ_AW-1:0] obj_waddr;
    object_t                 obj_wdata;
    logic                    start_refresh;
    logic [`CLIP_OBJ_AW:0]   num_objs;
    logic                    out_vld;
    clipped_line_t           out_line;
    logic [7:0]              line_cnt;
    logic [7:0]              reject_cnt;
    logic                    busy;
    logic                    refresh_done;

    object_t       shadow [`CLIP_OBJ_DEPTH]; // copy of what the host wrote
    clipped_line_t exp_q[$];
    clipped_line_t got_q[$];
    int            exp_lines;
    int            exp_rej;
    int            cycle_cnt = 0;
    logic [31:0]   lfsr_q = 32'h0450_6d6b;

    vector_clip_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .obj_wr        (obj_wr),
        .obj_waddr     (obj_waddr),
        .obj_wdata     (obj_wdata),
        .start_refresh (start_refresh),
        .num_objs      (num_objs),
        .out_vld       (out_vld),
        .out_line      (out_line),
        .line_cnt      (line_cnt),
        .reject_cnt    (reject_cnt),
        .busy          (busy),
        .refresh_done  (refresh_done)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "run stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            abort_run("timeout: the run went past its cycle limit");
        end
    end

    task automatic check_val(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "run stopped at first error");
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        int          k;
        v = 0;
        for (k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = (v << 1) | lfsr_q[0];
        end
        return v;
    endfunction

    function automatic int rand_coord();
        int r;
        r = take_bits(11);
        return (r % 1101) - 200; // -200 .. 900
    endfunction

    function automatic vertex_t make_vtx(input int x, input int y);
        vertex_t v;
        v.x = x[15:0];
        v.y = y[15:0];
        return v;
    endfunction

    function automatic object_t make_obj(input obj_kind_e k, input int c,
                                         input int x0, input int y0, input int x1, input int y1,
                                         input int x2, input int y2, input int x3, input int y3);
        object_t o;
        o.kind  = k;
        o.color = c[7:0];
        o.v0    = make_vtx(x0, y0);
        o.v1    = make_vtx(x1, y1);
        o.v2    = make_vtx(x2, y2);
        o.v3    = make_vtx(x3, y3);
        return o;
    endfunction

    // reference model
    function automatic outcode_t ref_outcode(input vertex_t v);
        outcode_t oc;
        int       x;
        int       y;
        x = v.x;
        y = v.y;
        oc.below = (y > `CLIP_SCREEN_H);
        oc.above = (y < 0);
        oc.right = (x > `CLIP_SCREEN_W);
        oc.left  = (x < 0);
        return oc;
    endfunction

    task automatic model_edge(input vertex_t a, input vertex_t b, input logic [7:0] c);
        clipped_line_t e;
        e.line.p0    = a;
        e.line.p1    = b;
        e.line.color = c;
        e.oc0        = ref_outcode(a);
        e.oc1        = ref_outcode(b);
        if ((e.oc0 | e.oc1) == 4'b0000) begin
            e.cls = cls_accept;
        end else if ((e.oc0 & e.oc1) != 4'b0000) begin
            e.cls = cls_reject;
        end else begin
            e.cls = cls_partial;
        end
        exp_lines++;
        if (e.cls == cls_reject) begin
            exp_rej++; // dropped by the DUT
        end else begin
            exp_q.push_back(e);
        end
    endtask

    task automatic model_object(input object_t o);
        case (o.kind)
            kind_point: model_edge(o.v0, o.v0, o.color);
            kind_line:  model_edge(o.v0, o.v1, o.color);
            kind_tri: begin
                model_edge(o.v0, o.v1, o.color);
                model_edge(o.v1, o.v2, o.color);
                model_edge(o.v2, o.v0, o.color);
            end
            default: begin
                model_edge(o.v0, o.v1, o.color);
                model_edge(o.v1, o.v2, o.color);
                model_edge(o.v2, o.v3, o.color);
                model_edge(o.v3, o.v0, o.color);
            end
        endcase
    endtask

    task automatic load_obj(input int addr, input object_t o);
        @(posedge clk);
        #2;
        obj_wr    = 1'b1;
        obj_waddr = addr[`CLIP_OBJ_AW-1:0];
        obj_wdata = o;
        shadow[addr] = o;
        @(posedge clk);
        #2;
        obj_wr = 1'b0;
    endtask

    task automatic compare_stream(input string name);
        int i;
        for (i = 0; i < exp_q.size(); i++) begin
            if (i >= got_q.size()) begin
                abort_run($sformatf("%s: output queue ran out at edge %0d", name, i));
            end else begin
                check_val($sformatf("%s edge %0d", name, i), 128'(exp_q[i]), 128'(got_q[i]));
            end
        end
        check_val({name, " edge count"}, 128'(exp_q.size()), 128'(got_q.size()));
        check_val({name, " line_cnt"}, 128'(exp_lines), 128'(line_cnt));
        check_val({name, " reject_cnt"}, 128'(exp_rej), 128'(reject_cnt));
        check_val({name, " busy after done"}, 128'(0), 128'(busy));
    endtask

    task automatic run_refresh(input string name, input int n);
        int waited;
        int limit;
        int i;
        exp_q.delete();
        got_q.delete();
        exp_lines = 0;
        exp_rej   = 0;
        for (i = 0; i < n; i++) begin
            model_object(shadow[i]);
        end
        limit = 4 * (n + 2) + 16;
        @(posedge clk);
        #2;
        num_objs      = n[`CLIP_OBJ_AW:0];
        start_refresh = 1'b1;
        @(posedge clk);
        #2;
        start_refresh = 1'b0;
        check_val({name, " busy during refresh"}, 128'(1), 128'(busy));
        waited = 0;
        do begin
            @(negedge clk);
            if (out_vld) begin
                got_q.push_back(out_line);
            end
            waited++;
        end while (!refresh_done && waited < limit);
        if (!refresh_done) begin
            abort_run($sformatf("%s: refresh_done never arrived", name));
        end else begin
            compare_stream(name);
        end
    endtask

    task automatic verify_reset_state();
        @(negedge clk);
        check_val("reset flags", 128'(0), 128'({out_vld, busy, refresh_done}));
        check_val("reset line_cnt", 128'(0), 128'(line_cnt));
        check_val("reset reject_cnt", 128'(0), 128'(reject_cnt));
    endtask

    task automatic point_and_line();
        load_obj(0, make_obj(kind_point, 8'h3c, 10, 20, 0, 0, 0, 0, 0, 0));
        load_obj(1, make_obj(kind_line, 8'ha5, 5, 5, 300, 200, 0, 0, 0, 0));
        run_refresh("point_line", 2);
        check_val("point_line point p0", 128'(make_vtx(10, 20)), 128'(got_q[0].line.p0));
        check_val("point_line point p1", 128'(make_vtx(10, 20)), 128'(got_q[0].line.p1));
        check_val("point_line point colour", 128'(8'h3c), 128'(got_q[0].line.color));
        check_val("point_line line colour", 128'(8'ha5), 128'(got_q[1].line.color));
        check_val("point_line line class", 128'(cls_accept), 128'(got_q[1].cls));
    endtask

    task automatic tri_and_quad();
        load_obj(0, make_obj(kind_tri, 1, 100, 100, 200, 100, 150, 200, 0, 0));
        load_obj(1, make_obj(kind_quad, 2, 10, 10, 50, 10, 50, 50, 10, 50));
        run_refresh("tri_quad", 2);
        check_val("tri_quad line_cnt", 128'(7), 128'(line_cnt));
        // closing edges
        check_val("tri_quad tri close p0", 128'(make_vtx(150, 200)), 128'(got_q[2].line.p0));
        check_val("tri_quad tri close p1", 128'(make_vtx(100, 100)), 128'(got_q[2].line.p1));
        check_val("tri_quad quad close p0", 128'(make_vtx(10, 50)), 128'(got_q[6].line.p0));
        check_val("tri_quad quad close p1", 128'(make_vtx(10, 10)), 128'(got_q[6].line.p1));
    endtask

    task automatic off_screen_edges();
        load_obj(0, make_obj(kind_line, 7, -50, 100, -10, 200, 0, 0, 0, 0));
        load_obj(1, make_obj(kind_line, 8, 600, 100, 700, 100, 0, 0, 0, 0));
        load_obj(2, make_obj(kind_line, 9, 0, 0, 640, 480, 0, 0, 0, 0));
        run_refresh("off_screen", 3);
        check_val("off_screen reject_cnt", 128'(1), 128'(reject_cnt));
        check_val("off_screen partial class", 128'(cls_partial), 128'(got_q[0].cls));
        check_val("off_screen partial oc1", 128'(4'b0010), 128'(got_q[0].oc1)); // right bit
        check_val("off_screen edge class", 128'(cls_accept), 128'(got_q[1].cls));
    endtask

    task automatic empty_then_recount();
        run_refresh("empty", 0);
        // off_screen objects are still in the store
        run_refresh("recount", 3);
        check_val("recount line_cnt", 128'(3), 128'(line_cnt));
    endtask

    task automatic random_objects();
        int      i;
        int      c;
        object_t o;
        for (i = 0; i < 40; i++) begin
            o.kind  = obj_kind_e'(take_bits(2));
            c       = take_bits(8);
            o.color = c[7:0];
            o.v0    = make_vtx(rand_coord(), rand_coord());
            o.v1    = make_vtx(rand_coord(), rand_coord());
            o.v2    = make_vtx(rand_coord(), rand_coord());
            o.v3    = make_vtx(rand_coord(), rand_coord());
            load_obj(i, o);
        end
        run_refresh("random", 40);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        obj_wr        = 1'b0;
        obj_waddr     = '0;
        obj_wdata     = '0;
        start_refresh = 1'b0;
        num_objs      = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        verify_reset_state();
        point_and_line();
        tri_and_quad();
        off_screen_edges();
        empty_then_recount();
        random_objects();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
geom_pkg.sv
seq_pkg.sv
obj_store.sv
clip_ctrl.sv
line_splitter.sv
line_classifier.sv
vector_clip_top.sv
tb_vector_clip.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_vector_clip
FILELIST   := files.f
VFLAGS     := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
